/* adc_mock.sv */
/*
  mock adc, ends a conversion after the aperture count
*/
`timescale 1ns/1ns
`default_nettype none

module adc_mock (
  input  wire logic                      clk,
  input  wire logic                      rst_i,
  input  wire logic                      reset_n_i,
  input  wire logic [dmm_pkg::CNT_W-1:0] aperture_i,
  output logic                           measure_valid_o
);

  logic [dmm_pkg::CNT_W-1:0] cnt;
  logic                      done;    // one valid per release

  always_ff @(posedge clk) begin
    if (rst_i || !reset_n_i) begin
      cnt             <= '0;
      done            <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= 1'b0;
      if (!done) begin
        if (cnt == aperture_i) begin
          measure_valid_o <= 1'b1;    // aperture + 1 clk after release
          done            <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dmm_pkg.sv */
/*
  dmm front-end shared definitions: register map, select codes,
  modes, sequencer states and the board control output bundle
*/
`default_nettype none

package dmm_pkg;

  ////////////////////
  // widths

  localparam int REG_W      = 32;    // spi register width
  localparam int CNT_W      = 24;    // precharge / aperture counters
  localparam int SEQ_N_W    = 3;
  localparam int SEQ_WORD_W = 6;

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;   // status bits 7:0

  ////////////////////
  // encodings

  // select vector, one device on the shared bus at a time
  typedef enum logic [2:0] {
    CS_NONE       = 3'd0,
    CS_FPGA       = 3'd1,
    CS_4094       = 3'd2,
    CS_INVERT_DAC = 3'd3,
    CS_MDAC       = 3'd4
  } spi_cs_e;

  typedef enum logic [6:0] {
    REG_MODE      = 7'h01,
    REG_DIRECT    = 7'h02,
    REG_4094_OE   = 7'h03,
    REG_APERTURE  = 7'h04,
    REG_PRECHARGE = 7'h05,
    REG_SEQ_N     = 7'h06,
    REG_STATUS    = 7'h07,    // read only
    REG_SEQ_BASE  = 7'h10     // + slot index
  } reg_addr_e;

  // other values park all pins low
  typedef enum logic [2:0] {
    MODE_DIRECT   = 3'd0,
    MODE_SEQ_MOCK = 3'd6
  } mode_e;

  typedef enum logic [1:0] {
    SEQ_IDLE      = 2'd0,
    SEQ_PRECHARGE = 2'd1,
    SEQ_CONVERT   = 2'd2
  } seq_state_e;

  ////////////////////
  // bundles

  typedef struct packed {
    logic [1:0] pc_sw;    // 5:4
    logic [3:0] azmux;    // 3:0
  } seq_word_t;

  // board control pins, msb first. direct reg maps 1:1
  typedef struct packed {
    logic       spi_interrupt;     // 23
    logic       adc_cmpr_latch;    // 22
    logic       adc_sigmux;        // 21
    logic       adc_rstmux;        // 20
    logic [1:0] adc_refmux;        // 19:18
    logic [3:0] azmux;             // 17:14
    logic [1:0] pc_sw;             // 13:12
    logic [7:0] monitor;           // 11:4
    logic [3:0] leds;              // 3:0
  } out_bundle_t;

  typedef struct packed {
    logic sck_rise;    // one clk pulse per sck rising edge
    logic mosi;
    logic sel;         // fpga selected
  } spi_pins_t;

endpackage

`default_nettype wire

/* dmm_top.sv */
/*
  dmm front-end fpga core. spi routing, register bank,
  mock-adc sequencer and the registered control outputs
*/
`timescale 1ns/1ns
`default_nettype none

module dmm_top #(
  parameter int NUM_SEQ = 4
) (
  input  wire logic             clk,
  input  wire logic             rst_i,
  // spi
  input  wire logic             sck_i,
  input  wire logic             sdi_i,
  input  wire dmm_pkg::spi_cs_e spi_cs_vec_i,
  output logic                  sdo_o,
  output logic                  spi_glb_clk_o,
  output logic                  spi_glb_mosi_o,
  output logic                  spi_4094_strobe_o,
  output logic                  spi_4094_oe_o,
  output logic                  spi_invert_dac_ss_o,
  output logic                  spi_iso_cs_o,
  input  wire logic [3:0]       hw_flags_i,
  input  wire logic             sa_trig_i,
  // board control
  output logic [3:0]            leds_o,
  output logic [7:0]            monitor_o,
  output logic [1:0]            pc_sw_o,
  output logic [3:0]            azmux_o,
  output logic [1:0]            adc_refmux_o,
  output logic                  adc_rstmux_o,
  output logic                  adc_sigmux_o,
  output logic                  adc_cmpr_latch_o,
  output logic                  spi_interrupt_o
);

  dmm_pkg::spi_pins_t                  pins;
  dmm_pkg::mode_e                      mode;
  dmm_pkg::out_bundle_t                direct, seq_bundle, out_pins;
  logic [dmm_pkg::CNT_W-1:0]           aperture, precharge;
  logic [dmm_pkg::SEQ_N_W-1:0]         seq_n;
  dmm_pkg::seq_word_t [NUM_SEQ-1:0]    seq_words;
  logic [2:0]                          sample_idx_last;
  logic                                adc_reset_n, measure_valid;

  spi_router spi_router_i (
    .clk, .rst_i, .sck_i, .sdi_i, .spi_cs_vec_i,
    .spi_glb_clk_o, .spi_glb_mosi_o, .spi_4094_strobe_o,
    .spi_invert_dac_ss_o, .spi_iso_cs_o,
    .pins_o (pins)
  );

  reg_bank #(.NUM_SEQ(NUM_SEQ)) reg_bank_i (
    .clk, .rst_i, .pins_i (pins), .hw_flags_i,
    .sample_idx_last_i (sample_idx_last),
    .sdo_o, .mode_o (mode), .direct_o (direct), .oe_4094_o (spi_4094_oe_o),
    .aperture_o (aperture), .precharge_o (precharge),
    .seq_n_o (seq_n), .seq_words_o (seq_words)
  );

  seq_acquisition #(.NUM_SEQ(NUM_SEQ)) seq_acquisition_i (
    .clk, .rst_i, .trig_i (sa_trig_i), .measure_valid_i (measure_valid),
    .precharge_i (precharge), .seq_n_i (seq_n), .seq_words_i (seq_words),
    .adc_reset_n_o (adc_reset_n), .bundle_o (seq_bundle),
    .sample_idx_last_o (sample_idx_last)
  );

  adc_mock adc_mock_i (
    .clk, .rst_i, .reset_n_i (adc_reset_n), .aperture_i (aperture),
    .measure_valid_o (measure_valid)
  );

  out_stage out_stage_i (
    .clk, .rst_i, .mode_i (mode), .direct_i (direct), .seq_i (seq_bundle),
    .pins_o (out_pins)
  );

  // unpack onto the pins
  assign leds_o           = out_pins.leds;
  assign monitor_o        = out_pins.monitor;
  assign pc_sw_o          = out_pins.pc_sw;
  assign azmux_o          = out_pins.azmux;
  assign adc_refmux_o     = out_pins.adc_refmux;
  assign adc_rstmux_o     = out_pins.adc_rstmux;
  assign adc_sigmux_o     = out_pins.adc_sigmux;
  assign adc_cmpr_latch_o = out_pins.adc_cmpr_latch;
  assign spi_interrupt_o  = out_pins.spi_interrupt;

endmodule

`default_nettype wire

/* out_stage.sv */
/*
  mode select for the board control pins, registered so the
  isolator inputs see clean edges
*/
`timescale 1ns/1ns
`default_nettype none

module out_stage (
  input  wire logic                 clk,
  input  wire logic                 rst_i,
  input  wire dmm_pkg::mode_e       mode_i,
  input  wire dmm_pkg::out_bundle_t direct_i,
  input  wire dmm_pkg::out_bundle_t seq_i,
  output dmm_pkg::out_bundle_t      pins_o
);

  dmm_pkg::out_bundle_t sel_bundle;

  // unknown modes drive everything low
  always_comb begin
    case (mode_i)
      dmm_pkg::MODE_DIRECT:   sel_bundle = direct_i;    // host drives every pin
      dmm_pkg::MODE_SEQ_MOCK: sel_bundle = seq_i;       // sequencer + mock adc
      default:                sel_bundle = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pins_o <= '0;
    end else begin
      pins_o <= sel_bundle;
    end
  end

endmodule

`default_nettype wire

/* project.f */
dmm_pkg.sv
spi_router.sv
reg_bank.sv
seq_acquisition.sv
adc_mock.sv
out_stage.sv
dmm_top.sv
tb_dmm.sv

/* reg_bank.sv */
/*
  spi register bank. 40 bit frames, cmd byte then 32 data bits,
  readback shifted out msb first, writes commit on deselect
*/
`timescale 1ns/1ns
`default_nettype none

module reg_bank #(
  parameter int NUM_SEQ = 4
) (
  input  wire logic                                      clk,
  input  wire logic                                      rst_i,
  input  wire dmm_pkg::spi_pins_t                        pins_i,
  input  wire logic [3:0]                                hw_flags_i,
  input  wire logic [2:0]                                sample_idx_last_i,
  output logic                                           sdo_o,
  output dmm_pkg::mode_e                                 mode_o,
  output dmm_pkg::out_bundle_t                           direct_o,
  output logic                                           oe_4094_o,
  output logic [dmm_pkg::CNT_W-1:0]                      aperture_o,
  output logic [dmm_pkg::CNT_W-1:0]                      precharge_o,
  output logic [dmm_pkg::SEQ_N_W-1:0]                    seq_n_o,
  output dmm_pkg::seq_word_t [NUM_SEQ-1:0]               seq_words_o
);

  logic [5:0]              bit_cnt;    // saturates, only 40 matters
  logic                    sel_q;
  logic                    sel_fall;
  logic [7:0]              cmd_sr;
  logic [7:0]              cmd_next;   // cmd including the bit arriving now
  logic [dmm_pkg::REG_W-1:0] data_sr;
  logic [dmm_pkg::REG_W-1:0] out_sr;
  logic [dmm_pkg::REG_W-1:0] rd_data;
  logic [6:0]              wr_addr;

  ////////////////////
  // frame shifter

  assign cmd_next = {cmd_sr[6:0], pins_i.mosi};
  assign sel_fall = sel_q & ~pins_i.sel;
  assign wr_addr  = cmd_sr[6:0];
  assign sdo_o    = pins_i.sel & out_sr[dmm_pkg::REG_W-1];    // quiet when not ours

  always_ff @(posedge clk) begin
    if (rst_i) begin
      bit_cnt <= '0;
      sel_q   <= 1'b0;
    end else begin
      sel_q <= pins_i.sel;
      if (!pins_i.sel) begin
        bit_cnt <= '0;
      end else if (pins_i.sck_rise && bit_cnt != 6'd63) begin
        bit_cnt <= bit_cnt + 6'd1;
      end
    end
  end

  // payload shifters
  always_ff @(posedge clk) begin
    if (!pins_i.sel) begin
      out_sr <= '0;
    end else if (pins_i.sck_rise) begin
      if (bit_cnt < 6'd8) begin
        cmd_sr <= cmd_next;
      end else begin
        data_sr <= {data_sr[dmm_pkg::REG_W-2:0], pins_i.mosi};
      end
      if (bit_cnt == 6'd7) begin
        out_sr <= rd_data;                       // first data bit ready before 9th edge
      end else if (bit_cnt >= 6'd8) begin
        out_sr <= {out_sr[dmm_pkg::REG_W-2:0], 1'b0};
      end
    end
  end

  ////////////////////
  // readback mux, addressed by the cmd byte as it completes

  always_comb begin
    rd_data = '0;
    case (cmd_next[6:0])
      dmm_pkg::REG_MODE:      rd_data[2:0] = mode_o;
      dmm_pkg::REG_DIRECT:    rd_data[23:0] = direct_o;
      dmm_pkg::REG_4094_OE:   rd_data[0] = oe_4094_o;
      dmm_pkg::REG_APERTURE:  rd_data[dmm_pkg::CNT_W-1:0] = aperture_o;
      dmm_pkg::REG_PRECHARGE: rd_data[dmm_pkg::CNT_W-1:0] = precharge_o;
      dmm_pkg::REG_SEQ_N:     rd_data[dmm_pkg::SEQ_N_W-1:0] = seq_n_o;
      dmm_pkg::REG_STATUS: begin
        rd_data[7:0]   = dmm_pkg::STATUS_MAGIC;
        rd_data[11:8]  = hw_flags_i;
        rd_data[18:16] = sample_idx_last_i;
        rd_data[22:20] = seq_n_o;
      end
      default: begin
        // seq slots, base + index
        if (cmd_next[6:0] >= dmm_pkg::REG_SEQ_BASE
            && cmd_next[6:0] < dmm_pkg::REG_SEQ_BASE + NUM_SEQ) begin
          rd_data[dmm_pkg::SEQ_WORD_W-1:0] = seq_words_o[cmd_next[2:0]];
        end
      end
    endcase
  end

  ////////////////////
  // register file, commit on clean 40 bit write frame

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mode_o      <= dmm_pkg::MODE_DIRECT;
      direct_o    <= '0;
      oe_4094_o   <= 1'b0;    // 4094 outputs off at power up
      aperture_o  <= '0;
      precharge_o <= '0;
      seq_n_o     <= '0;
      seq_words_o <= '0;
    end else if (sel_fall && bit_cnt == 6'd40 && cmd_sr[7]) begin
      case (wr_addr)
        dmm_pkg::REG_MODE:      mode_o      <= dmm_pkg::mode_e'(data_sr[2:0]);
        dmm_pkg::REG_DIRECT:    direct_o    <= data_sr[23:0];
        dmm_pkg::REG_4094_OE:   oe_4094_o   <= data_sr[0];
        dmm_pkg::REG_APERTURE:  aperture_o  <= data_sr[dmm_pkg::CNT_W-1:0];
        dmm_pkg::REG_PRECHARGE: precharge_o <= data_sr[dmm_pkg::CNT_W-1:0];
        dmm_pkg::REG_SEQ_N:     seq_n_o     <= data_sr[dmm_pkg::SEQ_N_W-1:0];
        default: begin
          if (wr_addr >= dmm_pkg::REG_SEQ_BASE
              && wr_addr < dmm_pkg::REG_SEQ_BASE + NUM_SEQ) begin
            seq_words_o[wr_addr[2:0]] <= data_sr[dmm_pkg::SEQ_WORD_W-1:0];
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the dmm testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_dmm -o tb_dmm
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_dmm)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

/* seq_acquisition.sv */
/*
  sample acquisition sequencer. per slot, precharge wait
  then one conversion, stepping azmux/pc switch settings
*/
`timescale 1ns/1ns
`default_nettype none

module seq_acquisition #(
  parameter int NUM_SEQ = 4
) (
  input  wire logic                                clk,
  input  wire logic                                rst_i,
  input  wire logic                                trig_i,
  input  wire logic                                measure_valid_i,
  input  wire logic [dmm_pkg::CNT_W-1:0]           precharge_i,
  input  wire logic [dmm_pkg::SEQ_N_W-1:0]         seq_n_i,
  input  wire dmm_pkg::seq_word_t [NUM_SEQ-1:0]    seq_words_i,
  output logic                                     adc_reset_n_o,
  output dmm_pkg::out_bundle_t                     bundle_o,
  output logic [2:0]                               sample_idx_last_o
);

  dmm_pkg::seq_state_e        state;
  logic [2:0]                 idx;
  logic [2:0]                 last_idx;
  logic [dmm_pkg::CNT_W-1:0]  cnt;
  logic                       wrap;
  dmm_pkg::seq_word_t         cur_word;

  ////////////////////
  // slot stepping

  // seq_n of 0 behaves as 1
  assign last_idx = (seq_n_i == '0) ? 3'd0 : seq_n_i - 3'd1;
  // never step past the implemented slots
  assign wrap     = (idx == last_idx) || (idx == NUM_SEQ - 1);
  assign cur_word = seq_words_i[idx];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state             <= dmm_pkg::SEQ_IDLE;
      idx               <= '0;
      cnt               <= '0;
      adc_reset_n_o     <= 1'b0;
      sample_idx_last_o <= '0;
    end else if (!trig_i) begin
      state         <= dmm_pkg::SEQ_IDLE;    // trig low, back to slot 0
      idx           <= '0;
      cnt           <= '0;
      adc_reset_n_o <= 1'b0;
    end else begin
      case (state)
        dmm_pkg::SEQ_IDLE: begin
          state <= dmm_pkg::SEQ_PRECHARGE;
          cnt   <= '0;
        end
        dmm_pkg::SEQ_PRECHARGE: begin
          if (cnt == precharge_i) begin
            state         <= dmm_pkg::SEQ_CONVERT;
            adc_reset_n_o <= 1'b1;             // let the adc run
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        dmm_pkg::SEQ_CONVERT: begin
          if (measure_valid_i) begin
            sample_idx_last_o <= idx;
            adc_reset_n_o     <= 1'b0;
            idx               <= wrap ? 3'd0 : idx + 3'd1;
            cnt               <= '0;
            state             <= dmm_pkg::SEQ_PRECHARGE;
          end
        end
        default: state <= dmm_pkg::SEQ_IDLE;
      endcase
    end
  end

  ////////////////////
  // outputs toward the mode mux

  always_comb begin
    bundle_o         = '0;
    bundle_o.leds    = 4'b0001 << idx;        // one-hot slot
    bundle_o.monitor = {3'b000, idx, state};  // state in 1:0, idx in 4:2
    if (state != dmm_pkg::SEQ_IDLE) begin
      bundle_o.azmux = cur_word.azmux;
      bundle_o.pc_sw = cur_word.pc_sw;
    end
  end

endmodule

`default_nettype wire

/* spi_router.sv */
/*
  spi select decode and shared bus parking, plus
  synchronizers that bring sck, sdi and the fpga select into clk
*/
`timescale 1ns/1ns
`default_nettype none

module spi_router (
  input  wire logic            clk,
  input  wire logic            rst_i,
  input  wire logic            sck_i,
  input  wire logic            sdi_i,
  input  wire dmm_pkg::spi_cs_e spi_cs_vec_i,
  output logic                 spi_glb_clk_o,
  output logic                 spi_glb_mosi_o,
  output logic                 spi_4094_strobe_o,
  output logic                 spi_invert_dac_ss_o,
  output logic                 spi_iso_cs_o,
  output dmm_pkg::spi_pins_t   pins_o
);

  logic fpga_sel;

  // two flop synchronizers, plus sck history for edge detect
  logic sck_meta, sck_sync, sck_prev;
  logic sdi_meta, sdi_sync;
  logic sel_meta, sel_sync;

  ////////////////////
  // select decode

  assign fpga_sel = (spi_cs_vec_i == dmm_pkg::CS_FPGA);

  assign spi_glb_clk_o  = fpga_sel ? 1'b1 : sck_i;    // park hi
  assign spi_glb_mosi_o = fpga_sel ? 1'b1 : sdi_i;    // park hi

  assign spi_4094_strobe_o   = (spi_cs_vec_i == dmm_pkg::CS_4094);          // active hi
  assign spi_invert_dac_ss_o = (spi_cs_vec_i != dmm_pkg::CS_INVERT_DAC);    // active lo
  assign spi_iso_cs_o        = (spi_cs_vec_i != dmm_pkg::CS_MDAC);          // active lo

  ////////////////////
  // sync into clk

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sck_meta <= 1'b0;
      sck_sync <= 1'b0;
      sck_prev <= 1'b0;
      sdi_meta <= 1'b0;
      sdi_sync <= 1'b0;
      sel_meta <= 1'b0;
      sel_sync <= 1'b0;
      pins_o   <= '0;
    end else begin
      sck_meta <= sck_i;
      sck_sync <= sck_meta;
      sck_prev <= sck_sync;
      sdi_meta <= sdi_i;
      sdi_sync <= sdi_meta;
      sel_meta <= fpga_sel;
      sel_sync <= sel_meta;
      // registered edge, 3 clk after the pin
      pins_o.sck_rise <= sck_sync & ~sck_prev;
      pins_o.mosi     <= sdi_sync;    // held stable across the rise in mode 0
      pins_o.sel      <= sel_sync;
    end
  end

endmodule

`default_nettype wire

/* tb_dmm.sv */
/*
  testbench for the dmm front-end core. spi host tasks,
  lfsr stimulus, shadow register model and pin checks
*/
`timescale 1ns/1ns
`default_nettype none

module tb_dmm;

  logic             clk;
  logic             rst;
  logic             sck, sdi, sdo;
  dmm_pkg::spi_cs_e spi_cs_vec;
  logic [3:0]       hw_flags;
  logic             sa_trig;
  logic             glb_clk, glb_mosi, strobe_4094, oe_4094, dac_ss, iso_cs;
  logic [3:0]       leds, azmux;
  logic [7:0]       monitor;
  logic [1:0]       pc_sw, refmux;
  logic             rstmux, sigmux, cmpr_latch, spi_int;
  logic [23:0]      pins_vec;    // out_bundle_t order
  logic [5:0]       sw_now;      // seq_word_t order

  logic [15:0] lfsr;
  logic [31:0] shadow [0:127];    // indexed by register address
  int          checks, errors;

  assign pins_vec = {spi_int, cmpr_latch, sigmux, rstmux, refmux,
                     azmux, pc_sw, monitor, leds};
  assign sw_now   = {pc_sw, azmux};

  dmm_top #(.NUM_SEQ(4)) dmm_top_i (
    .clk (clk), .rst_i (rst), .sck_i (sck), .sdi_i (sdi), .spi_cs_vec_i (spi_cs_vec),
    .sdo_o (sdo), .spi_glb_clk_o (glb_clk), .spi_glb_mosi_o (glb_mosi),
    .spi_4094_strobe_o (strobe_4094), .spi_4094_oe_o (oe_4094),
    .spi_invert_dac_ss_o (dac_ss), .spi_iso_cs_o (iso_cs),
    .hw_flags_i (hw_flags), .sa_trig_i (sa_trig),
    .leds_o (leds), .monitor_o (monitor), .pc_sw_o (pc_sw), .azmux_o (azmux),
    .adc_refmux_o (refmux), .adc_rstmux_o (rstmux), .adc_sigmux_o (sigmux),
    .adc_cmpr_latch_o (cmpr_latch), .spi_interrupt_o (spi_int)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = 1'b1;
      #50 clk = 1'b0;
    end
  end

  ////////////////////
  // helpers

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};    // one step per bit
    end
  endtask

  // writable width of each register
  function automatic logic [31:0] reg_mask(input logic [6:0] addr);
    case (addr)
      dmm_pkg::REG_MODE, dmm_pkg::REG_SEQ_N: return 32'h7;
      dmm_pkg::REG_4094_OE: return 32'h1;
      dmm_pkg::REG_DIRECT, dmm_pkg::REG_APERTURE, dmm_pkg::REG_PRECHARGE: return 32'hFF_FFFF;
      default: return 32'h3F;    // seq slots
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  // drive point, 10 ns after the rising edge
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  ////////////////////
  // spi host, mode 0, 4 clk per sck level

  task automatic spi_frame(input logic [7:0] cmd, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    logic [39:0] frame;
    frame      = {cmd, wdata};
    rdata      = '0;
    spi_cs_vec = dmm_pkg::CS_FPGA;
    step(6);    // sel through the synchronizer
    for (int b = 39; b >= 0; b--) begin
      sdi = frame[b];
      step(4);
      if (b < 32) begin
        rdata = {rdata[30:0], sdo};    // sample before the rise
      end
      sck = 1'b1;
      step(4);
      sck = 1'b0;
    end
    step(4);
    spi_cs_vec = dmm_pkg::CS_NONE;
    step(6);    // commit on deselect
  endtask

  task automatic reg_write(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    spi_frame({1'b1, addr}, data, rd);
    shadow[addr] = data & reg_mask(addr);
  endtask

  task automatic reg_read(input logic [6:0] addr, output logic [31:0] data);
    spi_frame({1'b0, addr}, 32'h0, data);
  endtask

  task automatic wait_pins(input logic [23:0] exp, input string what);
    int n;
    n = 0;
    while (pins_vec !== exp && n < 40) begin
      step(1);
      n++;
    end
    if (pins_vec !== exp) begin
      note_failure({"timed out waiting for ", what});
    end
  endtask

  // field map of out_bundle_t
  task automatic check_pins(input logic [23:0] exp);
    check_val("leds_o", leds, exp[3:0]);
    check_val("monitor_o", monitor, exp[11:4]);
    check_val("pc_sw_o", pc_sw, exp[13:12]);
    check_val("azmux_o", azmux, exp[17:14]);
    check_val("adc_refmux_o", refmux, exp[19:18]);
    check_val("adc_rstmux_o", rstmux, exp[20]);
    check_val("adc_sigmux_o", sigmux, exp[21]);
    check_val("adc_cmpr_latch_o", cmpr_latch, exp[22]);
    check_val("spi_interrupt_o", spi_int, exp[23]);
  endtask

  task automatic report_test(input int num, input string name, input int err0);
    if (errors == err0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - err0);
    end
  endtask

  ////////////////////
  // tests

  task automatic test_readback();
    logic [6:0]  addrs [10];
    logic [31:0] r;
    int          err0;
    err0  = errors;
    addrs = '{7'h01, 7'h02, 7'h03, 7'h04, 7'h05, 7'h06, 7'h10, 7'h11, 7'h12, 7'h13};
    foreach (addrs[i]) begin
      rand_bits(32, r);
      reg_write(addrs[i], r);
    end
    // read all after writing all, catches aliasing
    foreach (addrs[i]) begin
      reg_read(addrs[i], r);
      check_val($sformatf("reg 0x%02h", addrs[i]), r, shadow[addrs[i]]);
    end
    report_test(1, "register readback", err0);
  endtask

  task automatic test_status();
    logic [31:0] r, st, exp;
    int          err0;
    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      rand_bits(4, r);
      hw_flags = r[3:0];
      rand_bits(3, r);
      reg_write(dmm_pkg::REG_SEQ_N, r);
      reg_read(dmm_pkg::REG_STATUS, st);
      // no acquisition yet, last index still 0
      exp = {9'd0, r[2:0], 1'b0, 3'd0, 4'd0, hw_flags, dmm_pkg::STATUS_MAGIC};
      check_val("status", st, exp);
    end
    report_test(2, "status word", err0);
  endtask

  task automatic test_cs_decode();
    logic [31:0] r;
    int          err0;
    err0 = errors;
    for (int c = 0; c < 8; c++) begin
      rand_bits(2, r);
      spi_cs_vec = dmm_pkg::spi_cs_e'(c[2:0]);
      // both levels, parked lines must still read high
      for (int k = 0; k < 2; k++) begin
        sck = r[1] ^ k[0];
        sdi = r[0] ^ k[0];
        step(1);
        check_val("spi_4094_strobe_o", strobe_4094, c == 2);
        check_val("spi_invert_dac_ss_o", dac_ss, c != 3);    // active low
        check_val("spi_iso_cs_o", iso_cs, c != 4);
        check_val("spi_glb_clk_o", glb_clk, (c == 1) ? 1'b1 : sck);
        check_val("spi_glb_mosi_o", glb_mosi, (c == 1) ? 1'b1 : sdi);
      end
    end
    spi_cs_vec = dmm_pkg::CS_NONE;
    sck        = 1'b0;
    sdi        = 1'b0;
    step(6);    // partial frame drains
    report_test(3, "chip-select decode", err0);
  endtask

  task automatic test_direct();
    logic [31:0] r;
    int          err0;
    err0 = errors;
    reg_write(dmm_pkg::REG_MODE, dmm_pkg::MODE_DIRECT);
    for (int i = 0; i < 6; i++) begin
      rand_bits(24, r);
      reg_write(dmm_pkg::REG_DIRECT, r);
      wait_pins(r[23:0], "direct value on the pins");
      check_pins(r[23:0]);
      rand_bits(1, r);
      reg_write(dmm_pkg::REG_4094_OE, r);
      check_val("spi_4094_oe_o", oe_4094, r[0]);
    end
    report_test(4, "direct mode and 4094 oe", err0);
  endtask

  task automatic test_sequencer();
    logic [5:0]  words [4];
    logic [5:0]  prev;
    logic [31:0] r, st;
    logic        uniq;
    int          err0, tries, slot, changes, t;
    err0 = errors;
    reg_write(dmm_pkg::REG_MODE, dmm_pkg::MODE_SEQ_MOCK);
    reg_write(dmm_pkg::REG_PRECHARGE, 32'd3);    // short counts
    reg_write(dmm_pkg::REG_APERTURE, 32'd5);
    // distinct nonzero switch settings, idle shows zero
    for (int s = 0; s < 4; s++) begin
      tries = 0;
      do begin
        rand_bits(6, r);
        uniq = (r[5:0] != 6'd0);
        for (int j = 0; j < s; j++) begin
          if (words[j] == r[5:0]) begin
            uniq = 1'b0;
          end
        end
        tries++;
      end while (!uniq && tries < 64);
      if (!uniq) begin
        note_failure("could not draw distinct seq words");
      end
      words[s] = r[5:0];
      reg_write(7'(dmm_pkg::REG_SEQ_BASE + s), r);
    end
    for (int n = 1; n <= 4; n++) begin
      reg_write(dmm_pkg::REG_SEQ_N, n);
      sa_trig = 1'b1;
      t       = 0;
      while (sw_now == 6'd0 && t < 40) begin
        step(1);
        t++;
      end
      if (sw_now == 6'd0) begin
        note_failure("sequencer never applied a switch setting");
      end
      check_val("azmux/pc_sw slot 0", sw_now, words[0]);
      slot    = 0;
      changes = 0;
      prev    = sw_now;
      // observation window, roughly 25 slots
      for (int c = 0; c < 300; c++) begin
        step(1);
        if (sw_now != prev) begin
          slot = (slot + 1) % n;
          check_val($sformatf("azmux/pc_sw slot %0d", slot), sw_now, words[slot]);
          prev = sw_now;
          changes++;
        end
      end
      if (n == 1) begin
        check_val("slot changes with seq_n 1", changes, 0);
      end else if (changes < 2 * n) begin
        note_failure($sformatf("sequencer did not wrap with seq_n %0d", n));
      end
      reg_read(dmm_pkg::REG_STATUS, st);
      check_val("sample_idx_last below seq_n", st[18:16] < n, 1);
      sa_trig = 1'b0;
      t       = 0;
      while (sw_now != 6'd0 && t < 40) begin
        step(1);
        t++;
      end
      if (sw_now != 6'd0) begin
        note_failure("sequencer did not return to idle");
      end
    end
    report_test(5, "sequencer with mock adc", err0);
  endtask

  task automatic test_other_modes();
    logic [31:0] r;
    int          err0;
    err0 = errors;
    reg_write(dmm_pkg::REG_MODE, dmm_pkg::MODE_DIRECT);
    rand_bits(24, r);
    reg_write(dmm_pkg::REG_DIRECT, r | 32'h1);    // something to block
    sa_trig = 1'b1;
    for (int m = 1; m < 8; m++) begin
      if (m != 6) begin
        reg_write(dmm_pkg::REG_MODE, m);
        wait_pins(24'h0, $sformatf("all pins low in mode %0d", m));
        check_pins(24'h0);
      end
    end
    sa_trig = 1'b0;
    report_test(6, "other modes", err0);
  endtask

  ////////////////////
  // main sequence

  initial begin
    lfsr       = 16'd9841;
    checks     = 0;
    errors     = 0;
    rst        = 1'b1;
    sck        = 1'b0;
    sdi        = 1'b0;
    spi_cs_vec = dmm_pkg::CS_NONE;
    hw_flags   = 4'h0;
    sa_trig    = 1'b0;
    step(8);
    rst = 1'b0;
    step(4);
    test_readback();
    test_status();
    test_cs_decode();
    test_direct();
    test_sequencer();
    test_other_modes();
    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog, the whole run takes about 30k cycles
  initial begin
    for (int i = 0; i < 100000; i++) begin
      @(posedge clk);
    end
    $display("watchdog expired, the simulation did not finish");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
